/* verilog/accel_params.svh */
// Accelerator subsystem parameters
`ifndef ACCEL_PARAMS_SVH
`define ACCEL_PARAMS_SVH

// Byte address width
`define ADDR_W 32

// Data word width, four bytes per word
`define DATA_W 32

// Command length width in words
`define LEN_W 8

// Scalar cache line size in bytes
`define LINE_BYTES 16

// Outstanding transfers tracked by the arbiter
`define ARB_DEPTH 4

`endif

/* verilog/accel_pkg.sv */
// Accelerator shared types
`default_nettype none

`include "accel_params.svh"

package accel_pkg;

  typedef logic [`ADDR_W-1:0] addr_t;
  typedef logic [`DATA_W-1:0] data_t;
  typedef logic [`LEN_W-1:0]  len_t;

  // Dispatched command opcodes
  typedef enum logic {
    OP_COPY,
    OP_FILL
  } cmd_op_e;

  typedef enum logic [2:0] {
    IDLE,
    RD_REQ,
    RD_WAIT,
    WR_REQ,
    WR_WAIT,
    DONE
  } copy_state_e;

  // Configuration register offsets
  typedef enum logic [1:0] {
    REG_CTRL        = 2'd0,
    REG_INVAL_COUNT = 2'd1
  } cfg_addr_e;

endpackage

`default_nettype wire

/* verilog/mem_bus_if.sv */
// Single-beat memory bus
`timescale 1ns/1ps
`default_nettype none

interface mem_bus_if import accel_pkg::*; ();

  // Request channel
  logic  req_valid;
  logic  req_ready;
  logic  req_we;
  addr_t req_addr;
  data_t req_wdata;

  // Response channel, in request order
  logic  rsp_valid;
  logic  rsp_ready;
  data_t rsp_rdata;

  modport master (
    output req_valid, req_we, req_addr, req_wdata, rsp_ready,
    input  req_ready, rsp_valid, rsp_rdata
  );

  modport slave (
    input  req_valid, req_we, req_addr, req_wdata, rsp_ready,
    output req_ready, rsp_valid, rsp_rdata
  );

endinterface

`default_nettype wire

/* verilog/sys_config.sv */
// System configuration registers
`timescale 1ns/1ps
`default_nettype none

module sys_config import accel_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      cfg_valid_i,
  input  logic      cfg_we_i,
  input  cfg_addr_e cfg_addr_i,
  input  data_t     cfg_wdata_i,
  output logic      cfg_rvalid_o,
  output data_t     cfg_rdata_o,
  input  logic      inval_fire_i,
  output logic      inval_en_o
);

  logic  inval_en_q;
  data_t inval_count_q;
  logic  ctrl_wr;

  assign ctrl_wr    = cfg_valid_i && cfg_we_i && (cfg_addr_i == REG_CTRL);
  assign inval_en_o = inval_en_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      inval_en_q    <= 1'b0;
      inval_count_q <= '0;
      cfg_rvalid_o  <= 1'b0;
    end else begin
      cfg_rvalid_o <= cfg_valid_i && !cfg_we_i;
      if (ctrl_wr) begin
        inval_en_q    <= cfg_wdata_i[0];
        // Restart the count with the new setting
        inval_count_q <= '0;
      end else if (inval_fire_i) begin
        inval_count_q <= inval_count_q + 1'b1;
      end
    end
  end

  // Read data, one cycle after the request
  always_ff @(posedge clk_i) begin
    if (cfg_valid_i && !cfg_we_i) begin
      unique case (cfg_addr_i)
        REG_CTRL:        cfg_rdata_o <= data_t'(inval_en_q);
        REG_INVAL_COUNT: cfg_rdata_o <= inval_count_q;
        default:         cfg_rdata_o <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/vec_copy_unit.sv */
// Block copy accelerator
`timescale 1ns/1ps
`default_nettype none

module vec_copy_unit import accel_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      cmd_valid_i,
  output logic      cmd_ready_o,
  input  cmd_op_e   cmd_op_i,
  input  addr_t     cmd_src_i,
  input  addr_t     cmd_dst_i,
  input  len_t      cmd_len_i,
  output logic      rsp_valid_o,
  input  logic      rsp_ready_i,
  output len_t      rsp_words_o,
  mem_bus_if.master mem
);

  copy_state_e state_q, state_d;
  len_t        idx_q;
  cmd_op_e     op_q;
  addr_t       src_q;
  addr_t       dst_q;
  len_t        len_q;
  data_t       data_q;
  addr_t       offs;
  logic        cmd_fire;
  logic        last_word;

  assign cmd_fire  = cmd_valid_i && cmd_ready_o;
  assign offs      = addr_t'({idx_q, 2'b00});
  assign last_word = len_t'(idx_q + 1'b1) == len_q;

  ////////////////////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (cmd_valid_i)
          state_d = (cmd_op_i == OP_COPY) ? RD_REQ : WR_REQ;
      end
      RD_REQ: begin
        if (mem.req_ready)
          state_d = RD_WAIT;
      end
      RD_WAIT: begin
        if (mem.rsp_valid)
          state_d = WR_REQ;
      end
      WR_REQ: begin
        if (mem.req_ready)
          state_d = WR_WAIT;
      end
      WR_WAIT: begin
        if (mem.rsp_valid) begin
          if (last_word)
            state_d = DONE;
          else if (op_q == OP_COPY)
            state_d = RD_REQ;
          else
            state_d = WR_REQ;
        end
      end
      DONE: begin
        if (rsp_ready_i)
          state_d = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
      idx_q   <= '0;
    end else begin
      state_q <= state_d;
      if (cmd_fire)
        idx_q <= '0;
      else if (state_q == WR_WAIT && mem.rsp_valid)
        idx_q <= idx_q + 1'b1;
    end
  end

  // Command fields and the word in flight
  always_ff @(posedge clk_i) begin
    if (cmd_fire) begin
      op_q   <= cmd_op_i;
      src_q  <= cmd_src_i;
      dst_q  <= cmd_dst_i;
      len_q  <= cmd_len_i;
      // FILL keeps the pattern for every write
      data_q <= data_t'(cmd_src_i);
    end else if (state_q == RD_WAIT && mem.rsp_valid) begin
      data_q <= mem.rsp_rdata;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Bus and handshake outputs
  ////////////////////////////////////////////////////////////////////////////

  assign mem.req_valid = (state_q == RD_REQ) || (state_q == WR_REQ);
  assign mem.req_we    = (state_q == WR_REQ);
  assign mem.req_addr  = (state_q == WR_REQ) ? dst_q + offs : src_q + offs;
  assign mem.req_wdata = data_q;
  assign mem.rsp_ready = (state_q == RD_WAIT) || (state_q == WR_WAIT);

  assign cmd_ready_o = (state_q == IDLE);
  assign rsp_valid_o = (state_q == DONE);
  assign rsp_words_o = len_q;

  // The dispatcher never sends an empty command
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    cmd_fire |-> cmd_len_i != '0)
    else $error("Copy command with zero length accepted");

endmodule

`default_nettype wire

/* verilog/inval_filter.sv */
// Write invalidation filter
`timescale 1ns/1ps
`default_nettype none

`include "accel_params.svh"

module inval_filter import accel_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      en_i,
  mem_bus_if.slave  slv,
  mem_bus_if.master mst,
  output logic      inval_valid_o,
  input  logic      inval_ready_i,
  output addr_t     inval_addr_o,
  output logic      inval_fire_o
);

  localparam int unsigned LINE_OFF_W = $clog2(`LINE_BYTES);

  addr_t line_q;
  logic  line_vld_q;
  addr_t req_line;
  logic  need_inval;

  assign req_line = {slv.req_addr[`ADDR_W-1:LINE_OFF_W], {LINE_OFF_W{1'b0}}};

  // Writes to a line other than the last invalidated one wait
  assign need_inval = en_i && slv.req_valid && slv.req_we &&
                      !(line_vld_q && (line_q == req_line));

  assign inval_valid_o = need_inval;
  assign inval_addr_o  = req_line;
  assign inval_fire_o  = inval_valid_o && inval_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      line_vld_q <= 1'b0;
    end else if (!en_i) begin
      line_vld_q <= 1'b0;
    end else if (inval_fire_o) begin
      line_vld_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (inval_fire_o)
      line_q <= req_line;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Request and response paths
  ////////////////////////////////////////////////////////////////////////////

  assign mst.req_valid = slv.req_valid && !need_inval;
  assign mst.req_we    = slv.req_we;
  assign mst.req_addr  = slv.req_addr;
  assign mst.req_wdata = slv.req_wdata;
  assign slv.req_ready = mst.req_ready && !need_inval;

  assign slv.rsp_valid = mst.rsp_valid;
  assign slv.rsp_rdata = mst.rsp_rdata;
  assign mst.rsp_ready = slv.rsp_ready;

  // Upstream holds the write, so a refused invalidation keeps it blocked
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (en_i && $past(en_i && inval_valid_o && !inval_ready_i))
      |-> !(mst.req_valid && mst.req_we))
    else $error("Write forwarded while its invalidation is pending");

endmodule

`default_nettype wire

/* verilog/mem_arbiter.sv */
// Round-robin memory arbiter
`timescale 1ns/1ps
`default_nettype none

`include "accel_params.svh"

module mem_arbiter import accel_pkg::*; (
  input  logic     clk_i,
  input  logic     arst_n_i,
  mem_bus_if.slave port0,
  mem_bus_if.slave port1,
  output logic     mem_req_valid_o,
  input  logic     mem_req_ready_i,
  output logic     mem_req_we_o,
  output addr_t    mem_req_addr_o,
  output data_t    mem_req_wdata_o,
  input  logic     mem_rsp_valid_i,
  output logic     mem_rsp_ready_o,
  input  data_t    mem_rsp_rdata_i
);

  localparam int unsigned DEPTH = `ARB_DEPTH;
  localparam int unsigned PTR_W = $clog2(DEPTH);

  logic             rr_q;
  logic             hold_q;
  logic             hold_gnt_q;
  logic             arb_gnt;
  logic             gnt;
  logic             push;
  logic             pop;
  logic             fifo_full;
  logic             fifo_empty;
  logic             head_id;
  logic             id_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W:0]   cnt_q;

  ////////////////////////////////////////////////////////////////////////////
  // Request arbitration
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    if (port0.req_valid && port1.req_valid)
      arb_gnt = rr_q;
    else
      arb_gnt = port1.req_valid;
  end

  // A stalled request keeps its grant
  assign gnt = hold_q ? hold_gnt_q : arb_gnt;

  assign mem_req_valid_o = (port0.req_valid || port1.req_valid) && !fifo_full;
  assign mem_req_we_o    = gnt ? port1.req_we    : port0.req_we;
  assign mem_req_addr_o  = gnt ? port1.req_addr  : port0.req_addr;
  assign mem_req_wdata_o = gnt ? port1.req_wdata : port0.req_wdata;
  assign port0.req_ready = mem_req_ready_i && !fifo_full && !gnt;
  assign port1.req_ready = mem_req_ready_i && !fifo_full && gnt;

  assign push = mem_req_valid_o && mem_req_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rr_q       <= 1'b0;
      hold_q     <= 1'b0;
      hold_gnt_q <= 1'b0;
    end else begin
      hold_q     <= mem_req_valid_o && !mem_req_ready_i;
      hold_gnt_q <= gnt;
      if (push)
        rr_q <= ~gnt;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Source ID FIFO and response steering
  ////////////////////////////////////////////////////////////////////////////

  assign fifo_full  = cnt_q == (PTR_W+1)'(DEPTH);
  assign fifo_empty = cnt_q == '0;
  assign head_id    = id_q[rd_ptr_q];
  assign pop        = mem_rsp_valid_i && mem_rsp_ready_o;

  assign mem_rsp_ready_o = !fifo_empty && (head_id ? port1.rsp_ready : port0.rsp_ready);
  assign port0.rsp_valid = mem_rsp_valid_i && !fifo_empty && !head_id;
  assign port1.rsp_valid = mem_rsp_valid_i && !fifo_empty && head_id;
  assign port0.rsp_rdata = mem_rsp_rdata_i;
  assign port1.rsp_rdata = mem_rsp_rdata_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push)
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH-1)) ? '0 : wr_ptr_q + 1'b1;
      if (pop)
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH-1)) ? '0 : rd_ptr_q + 1'b1;
      unique case ({push, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push)
      id_q[wr_ptr_q] <= gnt;
  end

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    cnt_q <= (PTR_W+1)'(DEPTH))
    else $error("Arbiter ID FIFO overflow");

  // Memory answers only accepted requests
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mem_rsp_valid_i |-> !fifo_empty)
    else $error("Memory response with no outstanding request");

endmodule

`default_nettype wire

/* verilog/accel_system.sv */
// Accelerator subsystem top level
`timescale 1ns/1ps
`default_nettype none

module accel_system import accel_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,
  // Command dispatch
  input  logic      cmd_valid_i,
  output logic      cmd_ready_o,
  input  cmd_op_e   cmd_op_i,
  input  addr_t     cmd_src_i,
  input  addr_t     cmd_dst_i,
  input  len_t      cmd_len_i,
  output logic      rsp_valid_o,
  input  logic      rsp_ready_i,
  output len_t      rsp_words_o,
  // Narrow host port
  input  logic      host_req_valid_i,
  output logic      host_req_ready_o,
  input  logic      host_req_we_i,
  input  addr_t     host_req_addr_i,
  input  data_t     host_req_wdata_i,
  output logic      host_rsp_valid_o,
  input  logic      host_rsp_ready_i,
  output data_t     host_rsp_rdata_o,
  // Memory port
  output logic      mem_req_valid_o,
  input  logic      mem_req_ready_i,
  output logic      mem_req_we_o,
  output addr_t     mem_req_addr_o,
  output data_t     mem_req_wdata_o,
  input  logic      mem_rsp_valid_i,
  output logic      mem_rsp_ready_o,
  input  data_t     mem_rsp_rdata_i,
  // Scalar cache invalidation
  output logic      inval_valid_o,
  input  logic      inval_ready_i,
  output addr_t     inval_addr_o,
  // Configuration
  input  logic      cfg_valid_i,
  input  logic      cfg_we_i,
  input  cfg_addr_e cfg_addr_i,
  input  data_t     cfg_wdata_i,
  output logic      cfg_rvalid_o,
  output data_t     cfg_rdata_o
);

  logic inval_en;
  logic inval_fire;

  mem_bus_if copy_bus ();
  mem_bus_if filt_bus ();
  mem_bus_if host_bus ();

  assign host_bus.req_valid  = host_req_valid_i;
  assign host_bus.req_we     = host_req_we_i;
  assign host_bus.req_addr   = host_req_addr_i;
  assign host_bus.req_wdata  = host_req_wdata_i;
  assign host_bus.rsp_ready  = host_rsp_ready_i;
  assign host_req_ready_o    = host_bus.req_ready;
  assign host_rsp_valid_o    = host_bus.rsp_valid;
  assign host_rsp_rdata_o    = host_bus.rsp_rdata;

  sys_config i_sys_config (
    .clk_i       (clk_i       ),
    .arst_n_i    (arst_n_i    ),
    .cfg_valid_i (cfg_valid_i ),
    .cfg_we_i    (cfg_we_i    ),
    .cfg_addr_i  (cfg_addr_i  ),
    .cfg_wdata_i (cfg_wdata_i ),
    .cfg_rvalid_o(cfg_rvalid_o),
    .cfg_rdata_o (cfg_rdata_o ),
    .inval_fire_i(inval_fire  ),
    .inval_en_o  (inval_en    )
  );

  vec_copy_unit i_vec_copy_unit (
    .clk_i      (clk_i      ),
    .arst_n_i   (arst_n_i   ),
    .cmd_valid_i(cmd_valid_i),
    .cmd_ready_o(cmd_ready_o),
    .cmd_op_i   (cmd_op_i   ),
    .cmd_src_i  (cmd_src_i  ),
    .cmd_dst_i  (cmd_dst_i  ),
    .cmd_len_i  (cmd_len_i  ),
    .rsp_valid_o(rsp_valid_o),
    .rsp_ready_i(rsp_ready_i),
    .rsp_words_o(rsp_words_o),
    .mem        (copy_bus   )
  );

  inval_filter i_inval_filter (
    .clk_i        (clk_i        ),
    .arst_n_i     (arst_n_i     ),
    .en_i         (inval_en     ),
    .slv          (copy_bus     ),
    .mst          (filt_bus     ),
    .inval_valid_o(inval_valid_o),
    .inval_ready_i(inval_ready_i),
    .inval_addr_o (inval_addr_o ),
    .inval_fire_o (inval_fire   )
  );

  // Accelerator on port 0, host on port 1
  mem_arbiter i_mem_arbiter (
    .clk_i          (clk_i          ),
    .arst_n_i       (arst_n_i       ),
    .port0          (filt_bus       ),
    .port1          (host_bus       ),
    .mem_req_valid_o(mem_req_valid_o),
    .mem_req_ready_i(mem_req_ready_i),
    .mem_req_we_o   (mem_req_we_o   ),
    .mem_req_addr_o (mem_req_addr_o ),
    .mem_req_wdata_o(mem_req_wdata_o),
    .mem_rsp_valid_i(mem_rsp_valid_i),
    .mem_rsp_ready_o(mem_rsp_ready_o),
    .mem_rsp_rdata_i(mem_rsp_rdata_i)
  );

endmodule

`default_nettype wire

/* testbench/tb_mem_model.sv */
// Word memory model
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model import accel_pkg::*; (
  input  logic  clk_i,
  input  logic  arst_n_i,
  input  logic  stall_i,
  input  logic  req_valid_i,
  output logic  req_ready_o,
  input  logic  req_we_i,
  input  addr_t req_addr_i,
  input  data_t req_wdata_i,
  output logic  rsp_valid_o,
  input  logic  rsp_ready_i,
  output data_t rsp_rdata_o
);

  localparam int DEPTH = 8;

  data_t       mem_q [addr_t];
  data_t       rsp_buf [DEPTH];
  logic [2:0]  wr_ptr_q;
  logic [2:0]  rd_ptr_q;
  logic [3:0]  cnt_q;
  logic        push;
  logic        pop;

  // Accepted writes with the cycle they were taken in
  addr_t       wr_addr_log [$];
  int unsigned wr_cycle_log [$];
  int unsigned cycle_q = 0;

  assign req_ready_o = !stall_i && (cnt_q != 4'(DEPTH));
  assign push        = req_valid_i && req_ready_o;
  assign rsp_valid_o = cnt_q != 4'd0;
  assign rsp_rdata_o = rsp_buf[rd_ptr_q];
  assign pop         = rsp_valid_o && rsp_ready_i;

  // Unwritten words read back a pattern of their own address
  function automatic data_t read_word(input addr_t a);
    if (mem_q.exists(a))
      return mem_q[a];
    return a ^ 32'h5A3C_96E1;
  endfunction

  always @(posedge clk_i) begin
    cycle_q <= cycle_q + 1;
  end

  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        if (req_we_i) begin
          mem_q[req_addr_i] = req_wdata_i;
          wr_addr_log.push_back(req_addr_i);
          wr_cycle_log.push_back(cycle_q);
          rsp_buf[wr_ptr_q] <= '0;
        end else begin
          rsp_buf[wr_ptr_q] <= read_word(req_addr_i);
        end
        wr_ptr_q <= wr_ptr_q + 3'd1;
      end
      if (pop)
        rd_ptr_q <= rd_ptr_q + 3'd1;
      cnt_q <= cnt_q + 4'(push) - 4'(pop);
    end
  end

endmodule

`default_nettype wire

/* testbench/tb_accel_system.sv */
// Accelerator subsystem testbench
`timescale 1ns/1ps
`default_nettype none

`include "accel_params.svh"

module tb_accel_system import accel_pkg::*; ();

  localparam int    TIMEOUT   = 2000;
  localparam addr_t SRC_BASE  = 32'h0000_1000;
  localparam addr_t HOST_BASE = 32'h0000_8000;

  logic      clk_i = 1'b0;
  logic      arst_n_i;
  logic      cmd_valid_i;
  logic      cmd_ready_o;
  cmd_op_e   cmd_op_i;
  addr_t     cmd_src_i;
  addr_t     cmd_dst_i;
  len_t      cmd_len_i;
  logic      rsp_valid_o;
  logic      rsp_ready_i;
  len_t      rsp_words_o;
  logic      host_req_valid_i;
  logic      host_req_ready_o;
  logic      host_req_we_i;
  addr_t     host_req_addr_i;
  data_t     host_req_wdata_i;
  logic      host_rsp_valid_o;
  logic      host_rsp_ready_i;
  data_t     host_rsp_rdata_o;
  logic      mem_req_valid_o;
  logic      mem_req_ready_i;
  logic      mem_req_we_o;
  addr_t     mem_req_addr_o;
  data_t     mem_req_wdata_o;
  logic      mem_rsp_valid_i;
  logic      mem_rsp_ready_o;
  data_t     mem_rsp_rdata_i;
  logic      inval_valid_o;
  logic      inval_ready_i;
  addr_t     inval_addr_o;
  logic      cfg_valid_i;
  logic      cfg_we_i;
  cfg_addr_e cfg_addr_i;
  data_t     cfg_wdata_i;
  logic      cfg_rvalid_o;
  data_t     cfg_rdata_o;

  logic        mem_stall;
  logic        rand_stall;
  logic [31:0] seed;
  logic [31:0] stall_seed;
  data_t       src_data [32];
  int unsigned inval_valid_cycles = 0;
  addr_t       inval_log [$];
  int unsigned inval_cycle_log [$];

  accel_system accel_system_i (.*);

  tb_mem_model mem_i (
    .clk_i      (clk_i          ),
    .arst_n_i   (arst_n_i       ),
    .stall_i    (mem_stall      ),
    .req_valid_i(mem_req_valid_o),
    .req_ready_o(mem_req_ready_i),
    .req_we_i   (mem_req_we_o   ),
    .req_addr_i (mem_req_addr_o ),
    .req_wdata_i(mem_req_wdata_o),
    .rsp_valid_o(mem_rsp_valid_i),
    .rsp_ready_i(mem_rsp_ready_o),
    .rsp_rdata_o(mem_rsp_rdata_i)
  );

  always #2 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic addr_t line_of(input addr_t a);
    return a & ~addr_t'(`LINE_BYTES - 1);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Back-pressure and invalidation monitor
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    if (rand_stall) begin
      stall_seed = xorshift(stall_seed);
      inval_ready_i <= stall_seed[0];
      mem_stall     <= stall_seed[1] && stall_seed[2];
    end else begin
      inval_ready_i <= 1'b1;
      mem_stall     <= 1'b0;
    end
  end

  always @(posedge clk_i) begin
    if (arst_n_i) begin
      if (inval_valid_o)
        inval_valid_cycles++;
      if (inval_valid_o && inval_ready_i) begin
        inval_log.push_back(inval_addr_o);
        inval_cycle_log.push_back(mem_i.cycle_q);
      end
    end
  end

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAILED %s: got 0x%08h, expected 0x%08h", name, actual, expected);
      $display("Result: FAILED");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    $display("Result: FAILED");
    $fatal(1, "Wait timed out");
  endtask

  task automatic cfg_write(input cfg_addr_e addr, input data_t data);
    @(posedge clk_i);
    cfg_valid_i <= 1'b1;
    cfg_we_i    <= 1'b1;
    cfg_addr_i  <= addr;
    cfg_wdata_i <= data;
    @(posedge clk_i);
    cfg_valid_i <= 1'b0;
    cfg_we_i    <= 1'b0;
  endtask

  task automatic cfg_read(input cfg_addr_e addr, output data_t data);
    int n;
    n = 0;
    @(posedge clk_i);
    cfg_valid_i <= 1'b1;
    cfg_we_i    <= 1'b0;
    cfg_addr_i  <= addr;
    @(posedge clk_i);
    cfg_valid_i <= 1'b0;
    do begin
      @(posedge clk_i);
      n++;
      if (n > TIMEOUT)
        report_timeout("configuration read data");
    end while (!cfg_rvalid_o);
    data = cfg_rdata_o;
  endtask

  task automatic host_access(input logic we, input addr_t addr, input data_t wdata,
                             output data_t rdata);
    int n;
    n = 0;
    @(posedge clk_i);
    host_req_valid_i <= 1'b1;
    host_req_we_i    <= we;
    host_req_addr_i  <= addr;
    host_req_wdata_i <= wdata;
    do begin
      @(posedge clk_i);
      n++;
      if (n > TIMEOUT)
        report_timeout("host request acceptance");
    end while (!host_req_ready_o);
    host_req_valid_i <= 1'b0;
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
      if (n > TIMEOUT)
        report_timeout("host response");
    end while (!host_rsp_valid_o);
    rdata = host_rsp_rdata_o;
  endtask

  task automatic issue_command(input cmd_op_e op, input addr_t src, input addr_t dst,
                               input len_t len);
    int n;
    n = 0;
    @(posedge clk_i);
    cmd_valid_i <= 1'b1;
    cmd_op_i    <= op;
    cmd_src_i   <= src;
    cmd_dst_i   <= dst;
    cmd_len_i   <= len;
    do begin
      @(posedge clk_i);
      n++;
      if (n > TIMEOUT)
        report_timeout("command acceptance");
    end while (!cmd_ready_o);
    cmd_valid_i <= 1'b0;
  endtask

  // Response is held back one cycle to see that it stays valid
  task automatic wait_response(output len_t words);
    int n;
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
      if (n > TIMEOUT)
        report_timeout("command response");
    end while (!rsp_valid_o);
    words = rsp_words_o;
    rsp_ready_i <= 1'b1;
    @(posedge clk_i);
    check("rsp_valid_o", 32'(rsp_valid_o), 32'd1);
    rsp_ready_i <= 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic reset_test();
    data_t rdata;
    check("rsp_valid_o", 32'(rsp_valid_o), 32'd0);
    check("mem_req_valid_o", 32'(mem_req_valid_o), 32'd0);
    check("inval_valid_o", 32'(inval_valid_o), 32'd0);
    check("host_rsp_valid_o", 32'(host_rsp_valid_o), 32'd0);
    check("cfg_rvalid_o", 32'(cfg_rvalid_o), 32'd0);
    check("cmd_ready_o", 32'(cmd_ready_o), 32'd1);
    cfg_read(REG_CTRL, rdata);
    check("cfg_rdata_o", rdata, 32'd0);
    cfg_read(REG_INVAL_COUNT, rdata);
    check("cfg_rdata_o", rdata, 32'd0);
  endtask

  task automatic fill_test();
    addr_t       dst;
    len_t        len;
    data_t       value;
    data_t       rdata;
    len_t        words;
    int unsigned start;
    seed  = xorshift(seed);
    len   = len_t'(1 + seed % 20);
    seed  = xorshift(seed);
    value = seed;
    dst   = 32'h0000_4000;
    start = inval_valid_cycles;
    issue_command(OP_FILL, addr_t'(value), dst, len);
    wait_response(words);
    check("rsp_words_o", 32'(words), 32'(len));
    check("inval_valid_o", 32'(inval_valid_cycles - start), 32'd0);
    for (int i = 0; i < int'(len); i++) begin
      host_access(1'b0, dst + addr_t'(4 * i), '0, rdata);
      check("host_rsp_rdata_o", rdata, value);
    end
  endtask

  task automatic run_copy(input addr_t dst, input len_t len, input logic stalls);
    addr_t exp_lines [$];
    data_t rdata;
    len_t  words;
    int    wr_start;
    int    inv_start;
    int    j;
    // Stale destination data must not pass the compare
    for (int i = 0; i < int'(len); i++)
      host_access(1'b1, dst + addr_t'(4 * i), ~src_data[i], rdata);
    // Dropping the enable for a cycle forgets the last line
    cfg_write(REG_CTRL, 32'd0);
    cfg_write(REG_CTRL, 32'd1);
    wr_start  = mem_i.wr_addr_log.size();
    inv_start = inval_log.size();
    rand_stall <= stalls;
    issue_command(OP_COPY, SRC_BASE, dst, len);
    wait_response(words);
    rand_stall <= 1'b0;
    check("rsp_words_o", 32'(words), 32'(len));
    check("write count", 32'(mem_i.wr_addr_log.size() - wr_start), 32'(len));
    for (int i = 0; i < int'(len); i++) begin
      if (exp_lines.size() == 0 || exp_lines[$] != line_of(dst + addr_t'(4 * i)))
        exp_lines.push_back(line_of(dst + addr_t'(4 * i)));
    end
    check("invalidation count", 32'(inval_log.size() - inv_start), 32'(exp_lines.size()));
    for (int i = 0; i < exp_lines.size(); i++)
      check("inval_addr_o", inval_log[inv_start + i], exp_lines[i]);
    // Latest invalidation before each write must be for its line
    for (int w = wr_start; w < mem_i.wr_addr_log.size(); w++) begin
      j = -1;
      for (int k = inv_start; k < inval_log.size(); k++)
        if (inval_cycle_log[k] < mem_i.wr_cycle_log[w])
          j = k;
      if (j < 0 || inval_log[j] != line_of(mem_i.wr_addr_log[w])) begin
        $display("Write to 0x%08h was accepted before its line was invalidated",
                 mem_i.wr_addr_log[w]);
        $display("Result: FAILED");
        $fatal(1, "Invalidation order broken");
      end
    end
    cfg_read(REG_INVAL_COUNT, rdata);
    check("cfg_rdata_o", rdata, 32'(exp_lines.size()));
    for (int i = 0; i < int'(len); i++) begin
      host_access(1'b0, dst + addr_t'(4 * i), '0, rdata);
      check("host_rsp_rdata_o", rdata, src_data[i]);
    end
  endtask

  task automatic host_test(input addr_t dst, input len_t len);
    data_t host_data [8];
    data_t rdata;
    len_t  words;
    for (int i = 0; i < 4; i++) begin
      seed = xorshift(seed);
      host_data[i] = seed;
      host_access(1'b1, HOST_BASE + addr_t'(4 * i), host_data[i], rdata);
    end
    rand_stall <= 1'b1;
    fork
      begin
        issue_command(OP_COPY, SRC_BASE, dst, len);
        wait_response(words);
      end
      begin
        for (int i = 4; i < 8; i++) begin
          seed = xorshift(seed);
          host_data[i] = seed;
          host_access(1'b1, HOST_BASE + addr_t'(4 * i), host_data[i], rdata);
        end
        for (int i = 0; i < 8; i++) begin
          host_access(1'b0, HOST_BASE + addr_t'(4 * i), '0, rdata);
          check("host_rsp_rdata_o", rdata, host_data[i]);
        end
      end
    join
    rand_stall <= 1'b0;
    check("rsp_words_o", 32'(words), 32'(len));
    for (int i = 0; i < int'(len); i++) begin
      host_access(1'b0, dst + addr_t'(4 * i), '0, rdata);
      check("host_rsp_rdata_o", rdata, src_data[i]);
    end
  endtask

  initial begin
    addr_t dst;
    len_t  len;
    data_t rdata;
    seed             = 32'd57521;
    stall_seed       = xorshift(32'd57521);
    arst_n_i         = 1'b0;
    cmd_valid_i      = 1'b0;
    cmd_op_i         = OP_COPY;
    cmd_src_i        = '0;
    cmd_dst_i        = '0;
    cmd_len_i        = '0;
    rsp_ready_i      = 1'b0;
    host_req_valid_i = 1'b0;
    host_req_we_i    = 1'b0;
    host_req_addr_i  = '0;
    host_req_wdata_i = '0;
    host_rsp_ready_i = 1'b1;
    inval_ready_i    = 1'b1;
    cfg_valid_i      = 1'b0;
    cfg_we_i         = 1'b0;
    cfg_addr_i       = REG_CTRL;
    cfg_wdata_i      = '0;
    mem_stall        = 1'b0;
    rand_stall       = 1'b0;
    repeat (10) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(posedge clk_i);
    reset_test();
    fill_test();
    for (int i = 0; i < 32; i++) begin
      seed = xorshift(seed);
      src_data[i] = seed;
      host_access(1'b1, SRC_BASE + addr_t'(4 * i), src_data[i], rdata);
    end
    seed = xorshift(seed);
    len  = len_t'(4 + seed % 21);
    seed = xorshift(seed);
    // Start mid-line so the first line is partly written
    dst  = 32'h0000_2000 + addr_t'(4 * (seed % 4));
    run_copy(dst, len, 1'b0);
    run_copy(dst, len, 1'b1);
    host_test(dst + 32'h0000_1000, len);
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+verilog
verilog/accel_pkg.sv
verilog/mem_bus_if.sv
verilog/sys_config.sv
verilog/vec_copy_unit.sv
verilog/inval_filter.sv
verilog/mem_arbiter.sv
verilog/accel_system.sv
testbench/tb_mem_model.sv
testbench/tb_accel_system.sv

/* Makefile */
# Verilator build and run for the accelerator subsystem testbench

TOP := tb_accel_system

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f list.f

run: compile
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "Result: FAILED" sim.log; then \
		echo "Simulation reported a failure"; \
		exit 1; \
	fi
	@grep -q "Result: PASSED" sim.log || (echo "Simulation did not complete"; exit 1)

clean:
	rm -rf obj_dir sim.log
